/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
TOP       := fetch_ctrl_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'STATUS: PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+design
design/fetch_pkg.sv
design/irq_controller.sv
design/branch_predictor.sv
design/pc_sequencer.sv
design/fetch_ctrl_top.sv
dv/fetch_ctrl_tb.sv

/* design/branch_predictor.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branch_predictor (
	input  logic                   clk,
	input  logic                   nrst,
	input  fetch_pkg::pc_t         pc,
	input  fetch_pkg::exe_resolve_t exe_resolve,
	output fetch_pkg::prediction_t prediction
);

	localparam int IDX_W = $clog2(`BHT_DEPTH);
	localparam int TAG_W = `PC_W - 2 - IDX_W;	// Bits above index and word offset

	localparam logic [1:0] WEAK_NT = 2'b01;
	localparam logic [1:0] STRONG_T = 2'b11;
	localparam logic [1:0] STRONG_NT = 2'b00;

	logic [1:0]       bht_cnt [`BHT_DEPTH];
	logic [TAG_W-1:0] bht_tag [`BHT_DEPTH];
	fetch_pkg::pc_t   bht_tgt [`BHT_DEPTH];

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;
	logic [TAG_W-1:0] wr_tag;
	logic [1:0]       cur_cnt;
	logic [1:0]       new_cnt;

	// Fetch side lookup
	assign rd_idx = pc[IDX_W+1:2];
	assign rd_tag = pc[`PC_W-1:IDX_W+2];

	assign prediction.taken  = bht_cnt[rd_idx][1] && (bht_tag[rd_idx] == rd_tag);
	assign prediction.target = bht_tgt[rd_idx];

	// Execute side update
	assign wr_idx  = exe_resolve.branch_pc[IDX_W+1:2];
	assign wr_tag  = exe_resolve.branch_pc[`PC_W-1:IDX_W+2];
	assign cur_cnt = bht_cnt[wr_idx];

	always_comb begin
		new_cnt = cur_cnt;
		if (exe_resolve.taken) begin
			if (cur_cnt != STRONG_T)
				new_cnt = cur_cnt + 2'd1;
		end else begin
			if (cur_cnt != STRONG_NT)
				new_cnt = cur_cnt - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			for (int i = 0; i < `BHT_DEPTH; i++) begin
				bht_cnt[i] <= WEAK_NT;
			end
		end else if (exe_resolve.is_branch) begin
			bht_cnt[wr_idx] <= new_cnt;
		end
	end

	// Tag follows the last branch resolved into the entry
	always_ff @(posedge clk) begin
		if (exe_resolve.is_branch) begin
			bht_tag[wr_idx] <= wr_tag;
			if (exe_resolve.taken)
				bht_tgt[wr_idx] <= exe_resolve.target;
		end
	end

	a_corr_needs_branch: assert property (
		@(posedge clk) disable iff (!nrst)
		(exe_resolve.correction != fetch_pkg::CORR_NONE) |-> exe_resolve.is_branch
	) else $error("correction without is_branch");

endmodule

/* design/fetch_ctrl_top.sv */
`timescale 1ns/1ps

module fetch_ctrl_top (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    stall,	// From hazard unit
	input  logic                    int_sig,	// Active low
	input  logic [6:0]              if_opcode,
	input  fetch_pkg::id_jump_t     id_jump,
	input  fetch_pkg::exe_resolve_t exe_resolve,
	output fetch_pkg::pc_t          pc,
	output fetch_pkg::isr_ctrl_t    isr_ctrl
);

	fetch_pkg::prediction_t prediction;

	irq_controller u_irq (
		.clk            (clk),
		.nrst           (nrst),
		.stall          (stall),
		.int_sig        (int_sig),
		.if_opcode      (if_opcode),
		.pc             (pc),
		.pred_taken     (prediction.taken),
		.exe_correction (exe_resolve.correction),
		.id_jump        (id_jump),
		.isr_ctrl       (isr_ctrl)
	);

	branch_predictor u_bp (
		.clk         (clk),
		.nrst        (nrst),
		.pc          (pc),
		.exe_resolve (exe_resolve),
		.prediction  (prediction)
	);

	pc_sequencer u_pcs (
		.clk         (clk),
		.nrst        (nrst),
		.stall       (stall),
		.isr_ctrl    (isr_ctrl),
		.prediction  (prediction),
		.exe_resolve (exe_resolve),
		.id_jump     (id_jump),
		.pc          (pc)
	);

endmodule

/* design/fetch_pkg.sv */
`include "fetch_settings.svh"

package fetch_pkg;

	typedef logic [`PC_W-1:0] pc_t;	// One word address

	typedef enum logic [1:0] {
		CORR_NONE      = 2'b00,
		CORR_TAKEN     = 2'b01,	// Predicted not taken, was taken
		CORR_NOT_TAKEN = 2'b10	// Predicted taken, was not taken
	} correction_e;

	typedef enum logic [1:0] {
		IRQ_IDLE   = 2'b00,
		IRQ_DRAIN  = 2'b01,	// Pipeline drains before entry
		IRQ_RUN    = 2'b10,
		IRQ_RETURN = 2'b11	// URET seen, waiting for exit count
	} irq_state_e;

	typedef struct packed {
		logic        is_branch;
		logic        taken;
		correction_e correction;
		pc_t         branch_pc;
		pc_t         target;
	} exe_resolve_t;

	typedef struct packed {
		logic sel_pc;	// Decode wants to jump
		logic jump_in_bht;	// Already redirected by the predictor
		pc_t  target;
	} id_jump_t;

	typedef struct packed {
		logic taken;
		pc_t  target;
	} prediction_t;

	typedef struct packed {
		logic sel_isr;
		logic ret_isr;
		logic isr_flush;
		logic isr_running;
		pc_t  save_pc;	// Resume address after the routine
	} isr_ctrl_t;

endpackage

/* design/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction address width, one 32-bit word per fetch
`define PC_W 12

// Branch history table entries, power of two
`define BHT_DEPTH 16

// Fixed start address of the interrupt service routine
`define ISR_VECTOR 12'h100

// SYSTEM opcode, treated as URET at fetch
`define URET_OPCODE 7'h73

// Drain counter width and completion values
`define DRAIN_CNT_W 2
`define ENTRY_COUNT 2'd3
`define EXIT_COUNT 2'd2

`endif

/* design/irq_controller.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module irq_controller (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   stall,
	input  logic                   int_sig,	// Active low
	input  logic [6:0]             if_opcode,
	input  fetch_pkg::pc_t         pc,
	input  logic                   pred_taken,
	input  fetch_pkg::correction_e exe_correction,
	input  fetch_pkg::id_jump_t    id_jump,
	output fetch_pkg::isr_ctrl_t   isr_ctrl
);

	localparam logic [`DRAIN_CNT_W-1:0] CNT_ONE = 1;

	logic [`DRAIN_CNT_W-1:0] drain_cnt;
	logic                    isr_en;	// Cleared at entry and set again once int_sig is high
	logic                    sel_isr;
	logic                    ret_isr;
	logic                    isr_running;
	fetch_pkg::pc_t          save_pc;
	fetch_pkg::irq_state_e   state;

	logic uret_seen;
	logic drain_active;
	logic redirect;
	logic entry;
	logic uret_accept;
	logic entry_done;
	logic exit_done;
	logic save_pc_en;

	assign uret_seen    = (if_opcode == `URET_OPCODE);
	assign drain_active = (drain_cnt != '0) || uret_seen;	// Pipeline must not advance
	assign redirect     = (exe_correction != fetch_pkg::CORR_NONE) || pred_taken ||
	                      (id_jump.sel_pc && !id_jump.jump_in_bht);

	assign entry       = !int_sig && isr_en && !sel_isr;
	assign uret_accept = uret_seen && (state == fetch_pkg::IRQ_RUN);
	assign entry_done  = (drain_cnt == `ENTRY_COUNT) && !isr_running && !stall;
	assign exit_done   = (drain_cnt == `EXIT_COUNT) && isr_running && !stall;

	// Entry edge or any redirect landing while the pipe drains
	assign save_pc_en = (entry || (drain_active && redirect)) && !isr_running;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			drain_cnt   <= '0;
			isr_en      <= 1'b1;
			sel_isr     <= 1'b0;
			ret_isr     <= 1'b0;
			isr_running <= 1'b0;
			state       <= fetch_pkg::IRQ_IDLE;
		end else begin
			if (entry_done) begin
				drain_cnt   <= '0;
				isr_running <= 1'b1;
				sel_isr     <= 1'b1;
				state       <= fetch_pkg::IRQ_RUN;
			end else if (exit_done) begin
				drain_cnt   <= '0;
				isr_running <= 1'b0;
				ret_isr     <= 1'b0;
				state       <= fetch_pkg::IRQ_IDLE;
			end else if (uret_accept) begin
				drain_cnt <= CNT_ONE;	// Start return count
				ret_isr   <= 1'b1;
				sel_isr   <= 1'b0;
				state     <= fetch_pkg::IRQ_RETURN;
			end else if (entry) begin
				drain_cnt <= CNT_ONE;
				state     <= fetch_pkg::IRQ_DRAIN;
			end else if ((drain_cnt != '0) && !stall) begin
				drain_cnt <= drain_cnt + CNT_ONE;	// Frozen by stall
			end

			// No new entry until int_sig has been released while idle
			if (entry)
				isr_en <= 1'b0;
			else if (int_sig && !isr_running && !drain_active)
				isr_en <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst)
			save_pc <= '0;
		else if (save_pc_en)
			save_pc <= pc;
	end

	assign isr_ctrl.sel_isr     = sel_isr;
	assign isr_ctrl.ret_isr     = ret_isr;
	assign isr_ctrl.isr_flush   = drain_active && !ret_isr;
	assign isr_ctrl.isr_running = isr_running;
	assign isr_ctrl.save_pc     = save_pc;

	a_sel_ret_exclusive: assert property (
		@(posedge clk) disable iff (!nrst)
		!(sel_isr && ret_isr)
	) else $error("sel_isr and ret_isr high together");

	// Resume address is frozen once the routine runs
	a_save_pc_stable: assert property (
		@(posedge clk) disable iff (!nrst)
		isr_running |=> $stable(save_pc)
	) else $error("save_pc changed while isr_running");

endmodule

/* design/pc_sequencer.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pc_sequencer (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    stall,
	input  fetch_pkg::isr_ctrl_t    isr_ctrl,
	input  fetch_pkg::prediction_t  prediction,
	input  fetch_pkg::exe_resolve_t exe_resolve,
	input  fetch_pkg::id_jump_t     id_jump,
	output fetch_pkg::pc_t          pc
);

	localparam fetch_pkg::pc_t PC_STEP = 4;

	fetch_pkg::pc_t pc_q;
	fetch_pkg::pc_t pc_next;
	logic           sel_isr_q;	// Delayed copies for edge detect
	logic           running_q;
	logic           isr_enter;
	logic           isr_leave;

	assign isr_enter = isr_ctrl.sel_isr && !sel_isr_q;
	assign isr_leave = !isr_ctrl.isr_running && running_q;

	always_comb begin
		if (isr_enter)
			pc_next = `ISR_VECTOR;
		else if (isr_leave)
			pc_next = isr_ctrl.save_pc;	// Resume interrupted flow
		else if (isr_ctrl.isr_flush || stall)
			pc_next = pc_q;
		else if (exe_resolve.correction == fetch_pkg::CORR_TAKEN)
			pc_next = exe_resolve.target;
		else if (exe_resolve.correction == fetch_pkg::CORR_NOT_TAKEN)
			pc_next = exe_resolve.branch_pc + PC_STEP;
		else if (id_jump.sel_pc && !id_jump.jump_in_bht)
			pc_next = id_jump.target;	// Jump the predictor missed
		else if (prediction.taken)
			pc_next = prediction.target;
		else
			pc_next = pc_q + PC_STEP;
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			pc_q      <= '0;
			sel_isr_q <= 1'b0;
			running_q <= 1'b0;
		end else begin
			pc_q      <= pc_next;
			sel_isr_q <= isr_ctrl.sel_isr;
			running_q <= isr_ctrl.isr_running;
		end
	end

	assign pc = pc_q;

	// Every source of pc_next must be word aligned
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!nrst)
		pc_q[1:0] == 2'b00
	) else $error("pc not word aligned: %h", pc_q);

endmodule

/* dv/fetch_ctrl_tb.sv */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_ctrl_tb;

	localparam int IDX_W = $clog2(`BHT_DEPTH);
	localparam int WAIT_LIMIT = 50;
	localparam fetch_pkg::pc_t BR_PC = 12'h6a8;	// Trained branch, far from other code
	localparam fetch_pkg::pc_t BR_TGT = 12'h7f0;

	logic                    clk;
	logic                    nrst;
	logic                    stall;
	logic                    int_sig;
	logic [6:0]              if_opcode;
	fetch_pkg::id_jump_t     id_jump;
	fetch_pkg::exe_resolve_t exe_resolve;
	fetch_pkg::pc_t          pc;
	fetch_pkg::isr_ctrl_t    isr_ctrl;

	// Reference model state
	fetch_pkg::pc_t          m_pc;
	logic                    m_sel_q;
	logic                    m_run_q;
	logic [`DRAIN_CNT_W-1:0] m_cnt;
	logic                    m_en;
	logic                    m_sel;
	logic                    m_ret;
	logic                    m_run;
	fetch_pkg::pc_t          m_save;
	fetch_pkg::irq_state_e   m_phase;
	logic [1:0]              m_ctr [`BHT_DEPTH];
	fetch_pkg::pc_t          m_tag [`BHT_DEPTH];
	fetch_pkg::pc_t          m_tgt [`BHT_DEPTH];

	logic [31:0]             rng;
	fetch_pkg::pc_t          exp_save;

	fetch_ctrl_top uut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int bht_index(input fetch_pkg::pc_t a);
		return int'(a[IDX_W+1:2]);
	endfunction

	function automatic fetch_pkg::pc_t bht_tag(input fetch_pkg::pc_t a);
		return a >> (IDX_W + 2);
	endfunction

	function automatic logic predict_taken();
		int i;
		i = bht_index(m_pc);
		return m_ctr[i][1] && (m_tag[i] == bht_tag(m_pc));
	endfunction

	// Fetch holds while draining or on a URET that is not yet returning
	function automatic logic flush_now();
		return ((m_cnt != '0) || (if_opcode == `URET_OPCODE)) && !m_ret;
	endfunction

	function automatic fetch_pkg::pc_t next_pc();
		if (m_sel && !m_sel_q)
			return `ISR_VECTOR;
		if (!m_run && m_run_q)
			return m_save;
		if (flush_now() || stall)
			return m_pc;
		if (exe_resolve.correction == fetch_pkg::CORR_TAKEN)
			return exe_resolve.target;
		if (exe_resolve.correction == fetch_pkg::CORR_NOT_TAKEN)
			return exe_resolve.branch_pc + 12'd4;
		if (id_jump.sel_pc && !id_jump.jump_in_bht)
			return id_jump.target;
		if (predict_taken())
			return m_tgt[bht_index(m_pc)];
		return m_pc + 12'd4;
	endfunction

	function automatic fetch_pkg::isr_ctrl_t isr_value(input logic sel, input logic ret,
		input logic flush, input logic run, input fetch_pkg::pc_t save);
		fetch_pkg::isr_ctrl_t v;
		v.sel_isr     = sel;
		v.ret_isr     = ret;
		v.isr_flush   = flush;
		v.isr_running = run;
		v.save_pc     = save;
		return v;
	endfunction

	task automatic step_model();
		fetch_pkg::pc_t pc_n;
		logic           uret;
		logic           drain;
		logic           entry;
		logic           redirect;
		int             i;
		if (!nrst) begin
			m_pc    = '0;
			m_sel_q = 1'b0;
			m_run_q = 1'b0;
			m_cnt   = '0;
			m_en    = 1'b1;
			m_sel   = 1'b0;
			m_ret   = 1'b0;
			m_run   = 1'b0;
			m_save  = '0;
			m_phase = fetch_pkg::IRQ_IDLE;
			for (i = 0; i < `BHT_DEPTH; i++) begin
				m_ctr[i] = 2'b01;	// Weakly not taken
				m_tag[i] = '0;
				m_tgt[i] = '0;
			end
		end else begin
			pc_n     = next_pc();
			uret     = (if_opcode == `URET_OPCODE);
			drain    = (m_cnt != '0) || uret;
			entry    = !int_sig && m_en && !m_sel;
			redirect = (exe_resolve.correction != fetch_pkg::CORR_NONE) || predict_taken() ||
			           (id_jump.sel_pc && !id_jump.jump_in_bht);
			if ((entry || (drain && redirect)) && !m_run)
				m_save = m_pc;
			if (exe_resolve.is_branch) begin
				i = bht_index(exe_resolve.branch_pc);
				if (exe_resolve.taken) begin
					if (m_ctr[i] != 2'b11)
						m_ctr[i] = m_ctr[i] + 2'd1;
					m_tgt[i] = exe_resolve.target;
				end else if (m_ctr[i] != 2'b00) begin
					m_ctr[i] = m_ctr[i] - 2'd1;
				end
				m_tag[i] = bht_tag(exe_resolve.branch_pc);
			end
			if (entry)
				m_en = 1'b0;
			else if (int_sig && !m_run && !drain)
				m_en = 1'b1;	// Re-armed only after release
			m_sel_q = m_sel;
			m_run_q = m_run;
			if ((m_cnt == `ENTRY_COUNT) && !m_run && !stall) begin
				m_cnt   = '0;
				m_run   = 1'b1;
				m_sel   = 1'b1;
				m_phase = fetch_pkg::IRQ_RUN;
			end else if ((m_cnt == `EXIT_COUNT) && m_run && !stall) begin
				m_cnt   = '0;
				m_run   = 1'b0;
				m_ret   = 1'b0;
				m_phase = fetch_pkg::IRQ_IDLE;
			end else if (uret && (m_phase == fetch_pkg::IRQ_RUN)) begin
				m_cnt   = 2'd1;
				m_ret   = 1'b1;
				m_sel   = 1'b0;
				m_phase = fetch_pkg::IRQ_RETURN;
			end else if (entry) begin
				m_cnt   = 2'd1;
				m_phase = fetch_pkg::IRQ_DRAIN;
			end else if ((m_cnt != '0) && !stall) begin
				m_cnt = m_cnt + 2'd1;
			end
			m_pc = pc_n;
		end
	endtask

	task automatic abort_run(input string why);
		$display("STATUS: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_pc(input fetch_pkg::pc_t got, input fetch_pkg::pc_t exp);
		if (got !== exp) begin
			$display("error: pc got 0x%h expected 0x%h", got, exp);
			abort_run("pc mismatch");
		end
	endtask

	task automatic check_isr(input fetch_pkg::isr_ctrl_t got, input fetch_pkg::isr_ctrl_t exp);
		if (got !== exp) begin
			$display("error: isr_ctrl got 0x%h expected 0x%h", got, exp);
			abort_run("isr_ctrl mismatch");
		end
	endtask

	// Model advances on every edge, DUT is compared once outputs settle
	always @(posedge clk) begin
		step_model();
		#1;
		check_pc(pc, m_pc);
		check_isr(isr_ctrl, isr_value(m_sel, m_ret, flush_now(), m_run, m_save));
	end

	task automatic next_cycle();
		@(negedge clk);
		stall       = 1'b0;
		if_opcode   = '0;
		id_jump     = '0;
		exe_resolve = '0;
	endtask

	task automatic random_stall();
		rng   = xorshift32(rng);
		stall = (rng[1:0] == 2'b00);
	endtask

	task automatic run_sequential(input int n);
		repeat (n) begin
			next_cycle();
			random_stall();
		end
	endtask

	task automatic drive_resolve(input logic taken, input fetch_pkg::correction_e corr,
		input fetch_pkg::pc_t bpc, input fetch_pkg::pc_t tgt);
		next_cycle();
		exe_resolve.is_branch  = 1'b1;
		exe_resolve.taken      = taken;
		exe_resolve.correction = corr;
		exe_resolve.branch_pc  = bpc;
		exe_resolve.target     = tgt;
	endtask

	task automatic drive_jump(input fetch_pkg::pc_t tgt);
		next_cycle();
		id_jump.sel_pc      = 1'b1;
		id_jump.jump_in_bht = 1'b0;
		id_jump.target      = tgt;
	endtask

	task automatic enter_isr(input logic with_stall);
		int n;
		next_cycle();
		int_sig  = 1'b0;
		exp_save = m_pc;	// Address fetched at the entry edge
		next_cycle();
		check_isr(isr_ctrl, isr_value(1'b0, 1'b0, 1'b1, 1'b0, exp_save));
		n = 0;
		while (!isr_ctrl.sel_isr && (n < WAIT_LIMIT)) begin
			next_cycle();
			if (with_stall)
				random_stall();
			n++;
		end
		if (!isr_ctrl.sel_isr) begin
			$display("timeout: sel_isr never rose, model phase %s", m_phase.name());
			abort_run("interrupt entry timed out");
		end
		if (!with_stall && (n != 3)) begin
			$display("error: sel_isr delay got 0x%h expected 0x%h", n, 3);
			abort_run("interrupt entry delay wrong");
		end
		next_cycle();
		check_pc(pc, `ISR_VECTOR);
		check_isr(isr_ctrl, isr_value(1'b1, 1'b0, 1'b0, 1'b1, exp_save));
	endtask

	task automatic leave_isr();
		int n;
		next_cycle();
		if_opcode = `URET_OPCODE;
		next_cycle();
		check_isr(isr_ctrl, isr_value(1'b0, 1'b1, 1'b0, 1'b1, exp_save));
		n = 0;
		while (isr_ctrl.isr_running && (n < WAIT_LIMIT)) begin
			next_cycle();
			n++;
		end
		if (isr_ctrl.isr_running) begin
			$display("timeout: isr_running never fell, model phase %s", m_phase.name());
			abort_run("interrupt return timed out");
		end
		if (n != 2) begin
			$display("error: isr_running fall delay got 0x%h expected 0x%h", n, 2);
			abort_run("interrupt return delay wrong");
		end
		next_cycle();
		check_pc(pc, exp_save);
		check_isr(isr_ctrl, isr_value(1'b0, 1'b0, 1'b0, 1'b0, exp_save));
	endtask

	initial begin
		clk         = 1'b0;
		nrst        = 1'b0;
		stall       = 1'b0;
		int_sig     = 1'b1;
		if_opcode   = '0;
		id_jump     = '0;
		exe_resolve = '0;
		rng         = 32'd38868;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		check_pc(pc, '0);
		check_isr(isr_ctrl, isr_value(1'b0, 1'b0, 1'b0, 1'b0, '0));
		run_sequential(24);

		drive_resolve(1'b1, fetch_pkg::CORR_TAKEN, 12'h040, 12'h200);
		next_cycle();
		check_pc(pc, 12'h200);
		drive_resolve(1'b0, fetch_pkg::CORR_NOT_TAKEN, 12'h080, 12'h300);
		next_cycle();
		check_pc(pc, 12'h084);
		drive_jump(12'h3c0);
		next_cycle();
		check_pc(pc, 12'h3c0);

		// Two taken resolutions reach strongly taken
		drive_resolve(1'b1, fetch_pkg::CORR_NONE, BR_PC, BR_TGT);
		drive_resolve(1'b1, fetch_pkg::CORR_NONE, BR_PC, BR_TGT);
		drive_jump(BR_PC);
		next_cycle();
		check_pc(pc, BR_PC);
		next_cycle();
		check_pc(pc, BR_TGT);
		drive_resolve(1'b0, fetch_pkg::CORR_NONE, BR_PC, '0);
		drive_resolve(1'b0, fetch_pkg::CORR_NONE, BR_PC, '0);
		drive_jump(BR_PC);
		next_cycle();
		check_pc(pc, BR_PC);
		next_cycle();
		check_pc(pc, BR_PC + 12'd4);

		run_sequential(10);
		enter_isr(1'b0);
		run_sequential(6);
		leave_isr();
		repeat (4) begin
			next_cycle();	// int_sig still low, no new entry
			check_isr(isr_ctrl, isr_value(1'b0, 1'b0, 1'b0, 1'b0, exp_save));
		end
		next_cycle();
		int_sig = 1'b1;
		enter_isr(1'b1);
		run_sequential(6);
		leave_isr();
		int_sig = 1'b1;
		run_sequential(12);
		$display("STATUS: PASS");
		$finish;
	end

endmodule
